//--- game2048_cfg.svh
`ifndef GAME2048_CFG_SVH
`define GAME2048_CFG_SVH

// tile exponent: 0 empty, 1 is a 2, 11 is 2048
`define TILE_BITS 4

// cells per board side
`define BOARD_DIM 4

`define WIN_EXP 11

// screen geometry of the board in pixels
`define TILE_SIZE 41
`define TILE_PITCH 45
`define BOARD_X0 380
`define BOARD_Y0 180

// 4-bit red, green and blue
`define COLOR_BITS 12

// background words per game outcome
`define BG_PLAY 12'hFFF
`define BG_WIN 12'h080
`define BG_LOSE 12'h800

`define BLANK_COLOR 12'h666

`endif

//--- game2048Pkg.sv
`default_nettype none

`include "game2048_cfg.svh"

package game2048Pkg;

    typedef logic [`TILE_BITS-1:0] tileT;

    // index 0 is the edge that tiles slide toward
    typedef tileT [`BOARD_DIM-1:0] lineT;

    // indexed [row][col], row 0 at the top
    typedef tileT [`BOARD_DIM-1:0][`BOARD_DIM-1:0] boardT;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } keysT;

    typedef struct packed {
        logic [9:0] hCount;
        logic [9:0] vCount;
    } pixelPosT;

    typedef struct packed {
        logic [`COLOR_BITS/3-1:0] red;
        logic [`COLOR_BITS/3-1:0] green;
        logic [`COLOR_BITS/3-1:0] blue;
    } colorT;

    typedef enum logic [7:0] {
        I     = 8'b0000_0001,
        WAIT  = 8'b0000_0010,
        UP    = 8'b0000_0100,
        DOWN  = 8'b0000_1000,
        RIGHT = 8'b0001_0000,
        LEFT  = 8'b0010_0000,
        WIN   = 8'b0100_0000,
        LOSE  = 8'b1000_0000
    } gameStateT;

    function automatic colorT tileColor(tileT exponent);
        colorT color;
        case (exponent)
            4'd0:  color = `BLANK_COLOR;
            4'd1:  color = 12'hEDC;
            4'd2:  color = 12'hC98;
            4'd3:  color = 12'hD95;
            4'd4:  color = 12'hF84;
            4'd5:  color = 12'hF65;
            4'd6:  color = 12'hF33;
            4'd7:  color = 12'hEB4;
            4'd8:  color = 12'hFB0;
            4'd9:  color = 12'h8B5;
            4'd10: color = 12'h4AD;
            // 2048 and anything past it
            default: color = 12'h15D;
        endcase
        return color;
    endfunction

endpackage

`default_nettype wire

//--- lineSlider.sv
`default_nettype none

`include "game2048_cfg.svh"

module lineSlider (
    input  game2048Pkg::lineT lineIn,
    output game2048Pkg::lineT lineOut
);

    game2048Pkg::lineT work;

    // pairwise steps toward index 0:
    // (0,1), then (1,2) (0,1), then (2,3) (1,2) (0,1)
    // a tile may merge more than once in a single move
    always_comb begin
        work = lineIn;
        for (int s = 1; s < `BOARD_DIM; s++) begin
            for (int k = s - 1; k >= 0; k--) begin
                if (work[k] == '0) begin
                    work[k] = work[k+1];
                    work[k+1] = '0;
                end
                else if (work[k] == work[k+1]) begin
                    // equal exponents merge into the next power of two
                    work[k] = work[k] + 1'b1;
                    work[k+1] = '0;
                end
            end
        end
        lineOut = work;
    end

endmodule

`default_nettype wire

//--- moveNetwork.sv
`default_nettype none

`include "game2048_cfg.svh"

module moveNetwork (
    input  game2048Pkg::boardT     boardIn,
    input  game2048Pkg::gameStateT dir,
    output game2048Pkg::boardT     boardOut
);

    game2048Pkg::lineT linesIn [`BOARD_DIM];
    game2048Pkg::lineT linesOut [`BOARD_DIM];

    // gather lines so that index 0 sits on the edge of the move
    always_comb begin
        for (int i = 0; i < `BOARD_DIM; i++) begin
            for (int k = 0; k < `BOARD_DIM; k++) begin
                case (dir)
                    game2048Pkg::UP:    linesIn[i][k] = boardIn[k][i];
                    game2048Pkg::DOWN:  linesIn[i][k] = boardIn[`BOARD_DIM-1-k][i];
                    game2048Pkg::RIGHT: linesIn[i][k] = boardIn[i][`BOARD_DIM-1-k];
                    default:            linesIn[i][k] = boardIn[i][k];
                endcase
            end
        end
    end

    for (genvar i = 0; i < `BOARD_DIM; i++) begin : gSlide
        lineSlider lineSlider_i (
            .lineIn (linesIn[i]),
            .lineOut(linesOut[i])
        );
    end

    // scatter back in the same orientation
    always_comb begin
        boardOut = boardIn;
        for (int i = 0; i < `BOARD_DIM; i++) begin
            for (int k = 0; k < `BOARD_DIM; k++) begin
                case (dir)
                    game2048Pkg::UP:    boardOut[k][i] = linesOut[i][k];
                    game2048Pkg::DOWN:  boardOut[`BOARD_DIM-1-k][i] = linesOut[i][k];
                    game2048Pkg::LEFT:  boardOut[i][k] = linesOut[i][k];
                    game2048Pkg::RIGHT: boardOut[i][`BOARD_DIM-1-k] = linesOut[i][k];
                    // not a move, board passes unchanged
                    default:            boardOut[i][k] = boardIn[i][k];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- gameBoard.sv
`default_nettype none

`include "game2048_cfg.svh"

module gameBoard (
    input  logic                   Clk,
    input  logic                   Reset,
    input  game2048Pkg::gameStateT state,
    output game2048Pkg::boardT     board,
    output logic                   winFound,
    output logic                   boardFull
);

    game2048Pkg::boardT moved;
    game2048Pkg::boardT placed;
    logic pending;
    logic isMove;

    assign isMove = (state == game2048Pkg::UP) || (state == game2048Pkg::DOWN)
        || (state == game2048Pkg::LEFT) || (state == game2048Pkg::RIGHT);

    moveNetwork moveNetwork_i (
        .boardIn (board),
        .dir     (state),
        .boardOut(moved)
    );

    // new 2 goes into the first empty cell, row-major
    always_comb begin : placeNew
        logic found;
        found = 1'b0;
        placed = board;
        for (int r = 0; r < `BOARD_DIM; r++) begin
            for (int c = 0; c < `BOARD_DIM; c++) begin
                if (!found && board[r][c] == '0) begin
                    placed[r][c] = game2048Pkg::tileT'(1);
                    found = 1'b1;
                end
            end
        end
    end

    // status from the current register, ahead of any placement
    always_comb begin
        winFound = 1'b0;
        boardFull = 1'b1;
        for (int r = 0; r < `BOARD_DIM; r++) begin
            for (int c = 0; c < `BOARD_DIM; c++) begin
                if (board[r][c] == game2048Pkg::tileT'(`WIN_EXP)) begin
                    winFound = 1'b1;
                end
                if (board[r][c] == '0) begin
                    boardFull = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            pending <= 1'b0;
        end
        else if (state == game2048Pkg::I || isMove) begin
            pending <= 1'b1;
        end
        else if (state == game2048Pkg::WAIT) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (state == game2048Pkg::I) begin
            board <= '0;
            board[0][0] <= game2048Pkg::tileT'(1);
        end
        else if (isMove) begin
            board <= moved;
        end
        else if (state == game2048Pkg::WAIT && pending) begin
            board <= placed;
        end
    end

endmodule

`default_nettype wire

//--- gameFsm.sv
`default_nettype none

`include "game2048_cfg.svh"

module gameFsm (
    input  logic                   Clk,
    input  logic                   Reset,
    input  game2048Pkg::keysT      keys,
    input  logic                   winFound,
    input  logic                   boardFull,
    output game2048Pkg::gameStateT state,
    output game2048Pkg::colorT     background
);

    game2048Pkg::gameStateT nextState;

    always_comb begin
        case (state)
            game2048Pkg::I: begin
                nextState = game2048Pkg::WAIT;
            end
            game2048Pkg::WAIT: begin
                // end of game outranks any key
                if (winFound) begin
                    nextState = game2048Pkg::WIN;
                end
                else if (boardFull) begin
                    nextState = game2048Pkg::LOSE;
                end
                else if (keys.up) begin
                    nextState = game2048Pkg::UP;
                end
                else if (keys.down) begin
                    nextState = game2048Pkg::DOWN;
                end
                else if (keys.left) begin
                    nextState = game2048Pkg::LEFT;
                end
                else if (keys.right) begin
                    nextState = game2048Pkg::RIGHT;
                end
                else begin
                    nextState = game2048Pkg::WAIT;
                end
            end
            game2048Pkg::UP, game2048Pkg::DOWN,
            game2048Pkg::LEFT, game2048Pkg::RIGHT: begin
                nextState = game2048Pkg::WAIT;
            end
            game2048Pkg::WIN, game2048Pkg::LOSE: begin
                nextState = state;
            end
            // illegal encoding restarts the game
            default: begin
                nextState = game2048Pkg::I;
            end
        endcase
    end

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            state <= game2048Pkg::I;
            background <= `BG_PLAY;
        end
        else begin
            state <= nextState;
            // color follows one cycle into the end state
            if (state == game2048Pkg::WIN) begin
                background <= `BG_WIN;
            end
            else if (state == game2048Pkg::LOSE) begin
                background <= `BG_LOSE;
            end
        end
    end

endmodule

`default_nettype wire

//--- boardRenderer.sv
`default_nettype none

`include "game2048_cfg.svh"

module boardRenderer (
    input  game2048Pkg::pixelPosT pos,
    input  logic                  bright,
    input  game2048Pkg::boardT    board,
    input  game2048Pkg::colorT    background,
    output game2048Pkg::colorT    rgb
);

    localparam int IdxBits = $clog2(`BOARD_DIM);

    int dx;
    int dy;
    logic inTile;
    logic [IdxBits-1:0] cellRow;
    logic [IdxBits-1:0] cellCol;

    // offset from board corner, split into cell and position in cell
    always_comb begin
        dx = int'(pos.hCount) - `BOARD_X0;
        dy = int'(pos.vCount) - `BOARD_Y0;
        inTile = (dx >= 0) && (dy >= 0)
            && (dx / `TILE_PITCH < `BOARD_DIM) && (dy / `TILE_PITCH < `BOARD_DIM)
            && (dx % `TILE_PITCH < `TILE_SIZE) && (dy % `TILE_PITCH < `TILE_SIZE);
        cellCol = IdxBits'(dx / `TILE_PITCH);
        cellRow = IdxBits'(dy / `TILE_PITCH);
    end

    always_comb begin
        if (!bright) begin
            rgb = '0;
        end
        else if (inTile) begin
            rgb = game2048Pkg::tileColor(board[cellRow][cellCol]);
        end
        else begin
            // gaps and everything around the board
            rgb = background;
        end
    end

endmodule

`default_nettype wire

//--- game2048Top.sv
`default_nettype none

module game2048Top (
    input  logic                   Clk,
    input  logic                   Reset,
    input  game2048Pkg::keysT      keys,
    input  game2048Pkg::pixelPosT  pos,
    input  logic                   bright,
    output game2048Pkg::gameStateT state,
    output game2048Pkg::colorT     rgb,
    output game2048Pkg::colorT     background
);

    game2048Pkg::boardT board;
    logic winFound;
    logic boardFull;

    gameFsm gameFsm_i (
        .Clk       (Clk),
        .Reset     (Reset),
        .keys      (keys),
        .winFound  (winFound),
        .boardFull (boardFull),
        .state     (state),
        .background(background)
    );

    gameBoard gameBoard_i (
        .Clk      (Clk),
        .Reset    (Reset),
        .state    (state),
        .board    (board),
        .winFound (winFound),
        .boardFull(boardFull)
    );

    // pixel path, no clock
    boardRenderer boardRenderer_i (
        .pos       (pos),
        .bright    (bright),
        .board     (board),
        .background(background),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

//--- game2048_props.sv
`default_nettype none

`include "game2048_cfg.svh"

module game2048Props (
    input logic                   Clk,
    input logic                   Reset,
    input game2048Pkg::gameStateT state,
    input game2048Pkg::colorT     background
);

    timeunit 1ns;
    timeprecision 1ns;

    logic isMove;

    assign isMove = (state == game2048Pkg::UP) || (state == game2048Pkg::DOWN)
        || (state == game2048Pkg::LEFT) || (state == game2048Pkg::RIGHT);

    stateOneHot: assert property (@(posedge Clk) disable iff (Reset) $onehot(state))
        else $error("state register is not one-hot");

    // a move lasts one cycle
    moveToWait: assert property (@(posedge Clk) disable iff (Reset)
        isMove |=> state == game2048Pkg::WAIT)
        else $error("move state not followed by WAIT");

    winHolds: assert property (@(posedge Clk) disable iff (Reset)
        state == game2048Pkg::WIN |=> state == game2048Pkg::WIN)
        else $error("WIN state left before reset");

    loseHolds: assert property (@(posedge Clk) disable iff (Reset)
        state == game2048Pkg::LOSE |=> state == game2048Pkg::LOSE)
        else $error("LOSE state left before reset");

    winColor: assert property (@(posedge Clk) disable iff (Reset)
        state == game2048Pkg::WIN |=> background == `BG_WIN)
        else $error("background not green in WIN");

endmodule

bind gameFsm game2048Props game2048Props_i (
    .Clk       (Clk),
    .Reset     (Reset),
    .state     (state),
    .background(background)
);

`default_nettype wire

//--- game2048Tb.sv
`default_nettype none

`include "game2048_cfg.svh"

module game2048Tb;

    timeunit 1ns;
    timeprecision 1ns;

    // 21 cycles per random move for up to 2000 moves plus the directed tests
    localparam int CycleLimit = 60000;
    localparam int MaxRandomMoves = 2000;

    logic Clk = 1'b0;
    logic Reset;
    game2048Pkg::keysT keys;
    game2048Pkg::pixelPosT pos;
    logic bright;
    game2048Pkg::gameStateT state;
    game2048Pkg::colorT rgb;
    game2048Pkg::colorT background;

    // expected exponents by [row][col]
    int model [4][4];
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    integer seed = 64;

    game2048Top game2048Top_i (
        .Clk       (Clk),
        .Reset     (Reset),
        .keys      (keys),
        .pos       (pos),
        .bright    (bright),
        .state     (state),
        .rgb       (rgb),
        .background(background)
    );

    always #50 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic checkValue(input int actual, input int expected, input string what);
        checkCount++;
        assert (actual == expected) else begin
            errorCount++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic checkPixel(input int x, input int y, input logic on,
                              input game2048Pkg::colorT expected, input string what);
        @(posedge Clk);
        pos.hCount <= 10'(x);
        pos.vCount <= 10'(y);
        bright <= on;
        @(negedge Clk);
        checkValue(rgb, expected, $sformatf("rgb at (%0d,%0d) %s", x, y, what));
    endtask

    // one tile center per cycle
    task automatic readBoard();
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                checkPixel(`BOARD_X0 + c * `TILE_PITCH + 20, `BOARD_Y0 + r * `TILE_PITCH + 20,
                    1'b1, game2048Pkg::tileColor(game2048Pkg::tileT'(model[r][c])),
                    $sformatf("for cell (%0d,%0d)", r, c));
            end
        end
    endtask

    // k-th cell of line i with k = 0 on the edge of the move
    task automatic lineCell(input game2048Pkg::gameStateT dir, input int i, input int k,
                            output int r, output int c);
        r = (dir == game2048Pkg::UP) ? k : (dir == game2048Pkg::DOWN) ? 3 - k : i;
        c = (dir == game2048Pkg::LEFT) ? k : (dir == game2048Pkg::RIGHT) ? 3 - k : i;
    endtask

    task automatic moveModel(input game2048Pkg::gameStateT dir);
        int line [4];
        int r;
        int c;
        int near;
        // nearer cell of each pairwise step in order
        int steps [6] = '{0, 1, 0, 2, 1, 0};
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                lineCell(dir, i, k, r, c);
                line[k] = model[r][c];
            end
            foreach (steps[s]) begin
                near = steps[s];
                if (line[near] == 0) begin
                    line[near] = line[near+1];
                    line[near+1] = 0;
                end
                else if (line[near] == line[near+1]) begin
                    line[near]++;
                    line[near+1] = 0;
                end
            end
            for (int k = 0; k < 4; k++) begin
                lineCell(dir, i, k, r, c);
                model[r][c] = line[k];
            end
        end
    endtask

    task automatic placeModel();
        for (int n = 0; n < 16; n++) begin
            if (model[n/4][n%4] == 0) begin
                model[n/4][n%4] = 1;
                return;
            end
        end
    endtask

    function automatic bit winModel();
        foreach (model[r, c]) begin
            if (model[r][c] == `WIN_EXP) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic bit fullModel();
        foreach (model[r, c]) begin
            if (model[r][c] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic waitForState(input game2048Pkg::gameStateT expected);
        while (state != expected) begin
            @(negedge Clk);
        end
    endtask

    task automatic doMove(input game2048Pkg::gameStateT dir);
        game2048Pkg::keysT pressed;
        game2048Pkg::gameStateT expected;
        pressed = '0;
        pressed.up = (dir == game2048Pkg::UP);
        pressed.down = (dir == game2048Pkg::DOWN);
        pressed.left = (dir == game2048Pkg::LEFT);
        pressed.right = (dir == game2048Pkg::RIGHT);
        waitForState(game2048Pkg::WAIT);
        @(posedge Clk);
        keys <= pressed;
        @(posedge Clk);
        keys <= '0;
        @(negedge Clk);
        checkValue(state, dir, "state after key pulse");
        moveModel(dir);
        placeModel();
        // the move, the placement and the end check on the placed board
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        expected = winModel() ? game2048Pkg::WIN
            : fullModel() ? game2048Pkg::LOSE : game2048Pkg::WAIT;
        checkValue(state, expected, "state after move");
        readBoard();
    endtask

    task automatic resetTest();
        repeat (10) @(posedge Clk);
        Reset <= 1'b0;
        @(negedge Clk);
        checkValue(state, game2048Pkg::I, "state after reset");
        checkValue(background, `BG_PLAY, "background after reset");
        @(negedge Clk);
        checkValue(state, game2048Pkg::WAIT, "state one cycle after reset");
        model = '{default: 0};
        model[0][0] = 1;
        placeModel();
        @(negedge Clk);
        readBoard();
    endtask

    task automatic holdLeft();
        waitForState(game2048Pkg::WAIT);
        @(posedge Clk);
        keys <= '{up: 1'b0, down: 1'b0, left: 1'b1, right: 1'b0};
        repeat (6) @(posedge Clk);
        keys <= '0;
        repeat (3) begin
            moveModel(game2048Pkg::LEFT);
            placeModel();
        end
        // last placement
        @(posedge Clk);
        @(negedge Clk);
        checkValue(state, game2048Pkg::WAIT, "state after held key");
        readBoard();
    endtask

    task automatic pixelTest();
        checkPixel(`BOARD_X0 + `TILE_SIZE, `BOARD_Y0 + 10, 1'b1, `BG_PLAY, "gap right");
        checkPixel(`BOARD_X0 + 10, `BOARD_Y0 + `TILE_PITCH - 1, 1'b1, `BG_PLAY, "gap below");
        checkPixel(`BOARD_X0 - 1, `BOARD_Y0, 1'b1, `BG_PLAY, "left of board");
        checkPixel(`BOARD_X0, `BOARD_Y0 - 1, 1'b1, `BG_PLAY, "above board");
        checkPixel(`BOARD_X0 + 4 * `TILE_PITCH, `BOARD_Y0, 1'b1, `BG_PLAY, "right of board");
        checkPixel(`BOARD_X0, `BOARD_Y0 + 4 * `TILE_PITCH, 1'b1, `BG_PLAY, "below board");
        checkPixel(`BOARD_X0 + 40, `BOARD_Y0 + 40, 1'b1,
            game2048Pkg::tileColor(game2048Pkg::tileT'(model[0][0])), "last tile pixel");
        for (int i = 0; i < 16; i++) begin
            checkPixel(`BOARD_X0 + i * 23, `BOARD_Y0 + i * 13, 1'b0, '0, "blanked");
        end
    endtask

    task automatic randomPlay();
        int moves;
        game2048Pkg::gameStateT dir;
        moves = 0;
        while (!winModel() && !fullModel() && moves < MaxRandomMoves) begin
            case ($random(seed) & 3)
                0: dir = game2048Pkg::UP;
                1: dir = game2048Pkg::DOWN;
                2: dir = game2048Pkg::LEFT;
                default: dir = game2048Pkg::RIGHT;
            endcase
            doMove(dir);
            moves++;
        end
        @(negedge Clk);
        if (winModel()) begin
            checkValue(background, `BG_WIN, "background after win");
        end
        else if (fullModel()) begin
            checkValue(background, `BG_LOSE, "background after loss");
        end
        else begin
            errorCount++;
            $display("random play ended after %0d moves with neither a win nor a loss", moves);
        end
    endtask

    initial begin
        Reset = 1'b1;
        keys = '0;
        pos = '0;
        bright = 1'b0;
        resetTest();
        doMove(game2048Pkg::LEFT);
        doMove(game2048Pkg::LEFT);
        // 4,2,2 in row 0 merges twice into one 8
        doMove(game2048Pkg::LEFT);
        checkPixel(`BOARD_X0 + 20, `BOARD_Y0 + 20, 1'b1, game2048Pkg::tileColor(4'd3),
            "double merge");
        doMove(game2048Pkg::DOWN);
        doMove(game2048Pkg::RIGHT);
        doMove(game2048Pkg::UP);
        holdLeft();
        pixelTest();
        randomPlay();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
game2048Pkg.sv
lineSlider.sv
moveNetwork.sv
gameBoard.sv
gameFsm.sv
boardRenderer.sv
game2048Top.sv
game2048_props.sv
game2048Tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module game2048Tb -o game2048Sim
./obj_dir/game2048Sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
# a run that stopped early printed no result
grep -q "Done: no errors" sim.log
